// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int DATA_WIDTH    = 32;
  localparam int ADDR_WIDTH    = 12;
  localparam int MEM_WORDS     = 4096;
  localparam int REG_IDX_WIDTH = 5;
  localparam int FREE_WIDTH    = 13;                  // Bits 31..19 of the register view
  localparam int OFFSET_WIDTH  = 18;                  // Bits 31..14 of the memory view

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  localparam addr_t RESET_PC = 12'd1;                 // First fetch address

  // Opcodes 6, 14 and 15 are unused and retire as no-ops
  typedef enum logic [3:0] {
    ADD = 4'd0,
    LW  = 4'd1,
    SW  = 4'd2,
    SUB = 4'd3,
    AND = 4'd4,
    MUL = 4'd5,
    OR  = 4'd7,
    XOR = 4'd8,
    BEQ = 4'd9,
    BNE = 4'd10,
    BLT = 4'd11,
    BGE = 4'd12,
    JMP = 4'd13
  } opcode_e;

  typedef struct packed {
    logic [FREE_WIDTH-1:0]    free;
    logic [REG_IDX_WIDTH-1:0] ra;
    logic [REG_IDX_WIDTH-1:0] rb;
    logic [REG_IDX_WIDTH-1:0] rd;
    opcode_e                  opcode;
  } instr_r_t;

  typedef struct packed {
    logic [OFFSET_WIDTH-1:0]  offset;                 // Signed word offset
    logic [REG_IDX_WIDTH-1:0] rb;
    logic [REG_IDX_WIDTH-1:0] rd;
    opcode_e                  opcode;
  } instr_m_t;

  typedef union packed {
    instr_r_t r;                                      // ALU, branch and jump view
    instr_m_t m;                                      // LW and SW view
  } instr_u;

endpackage

`default_nettype wire

// ==== hdl/pipe_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decode to execute
interface dec_ex_if;
  logic            valid;
  cpu_pkg::addr_t  pc;
  cpu_pkg::instr_u instr;
  cpu_pkg::word_t  op_a;                              // Value of ra
  cpu_pkg::word_t  op_b;                              // Value of rb
  cpu_pkg::word_t  op_d;                              // Value of rd, store data

  modport source (output valid, pc, instr, op_a, op_b, op_d);
  modport sink   (input  valid, pc, instr, op_a, op_b, op_d);
endinterface

// Execute to writeback
interface ex_wb_if;
  logic            valid;
  cpu_pkg::addr_t  pc;
  cpu_pkg::instr_u instr;
  cpu_pkg::word_t  result;                            // ALU result
  logic            reg_we;
  logic            is_load;                           // Take data from memory instead
  logic            store_en;
  cpu_pkg::addr_t  store_addr;
  cpu_pkg::word_t  store_data;

  modport source (
    output valid, pc, instr, result, reg_we, is_load, store_en, store_addr, store_data
  );
  modport sink (
    input  valid, pc, instr, result, reg_we, is_load, store_en, store_addr, store_data
  );
endinterface

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic           run_i,
  input  logic           stall_i,
  input  logic           redirect_i,
  input  cpu_pkg::addr_t redirect_pc_i,
  output cpu_pkg::addr_t fetch_addr_o,
  output logic           fetch_valid_o,
  output cpu_pkg::addr_t fetch_pc_o
);

  cpu_pkg::addr_t pc_q;

  assign fetch_addr_o = pc_q;                         // To the instruction read port

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc_q          <= cpu_pkg::RESET_PC;
      fetch_valid_o <= 1'b0;
    end else begin
      if (redirect_i) begin
        pc_q <= redirect_pc_i;                        // Branch wins over stall
      end else if (run_i && !stall_i) begin
        pc_q <= pc_q + 1'b1;                          // Wraps at 4096
      end
      fetch_valid_o <= run_i && !redirect_i;          // Word in flight is dropped
    end
  end

  // Address of the word the memory returns next cycle
  always_ff @(posedge clk) begin
    fetch_pc_o <= pc_q;
  end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              fetch_valid_i,
  input  cpu_pkg::addr_t                    fetch_pc_i,
  input  cpu_pkg::instr_u                   fetch_instr_i,
  input  logic                              redirect_i,
  input  logic [cpu_pkg::REG_IDX_WIDTH-1:0] ex_rd_i,
  input  logic                              ex_we_i,
  input  logic [cpu_pkg::REG_IDX_WIDTH-1:0] wb_rd_i,
  input  logic                              wb_we_i,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] rf_ra_o,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] rf_rb_o,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] rf_rd_o,
  input  cpu_pkg::word_t                    rf_a_i,
  input  cpu_pkg::word_t                    rf_b_i,
  input  cpu_pkg::word_t                    rf_d_i,
  output logic                              stall_o,
  dec_ex_if.source                          dx
);

  logic            hold_q;                            // Decoding the held word
  cpu_pkg::addr_t  held_pc_q;
  cpu_pkg::instr_u held_instr_q;
  logic            cur_valid;
  cpu_pkg::addr_t  cur_pc;
  cpu_pkg::instr_u cur_instr;
  logic            use_a;
  logic            use_b;
  logic            use_d;
  logic            hit_a;
  logic            hit_b;
  logic            hit_d;

  // The memory has moved on during a stall, so the word is kept here
  assign cur_valid = hold_q || fetch_valid_i;
  assign cur_pc    = hold_q ? held_pc_q : fetch_pc_i;
  assign cur_instr = hold_q ? held_instr_q : fetch_instr_i;

  assign rf_ra_o = cur_instr.r.ra;
  assign rf_rb_o = cur_instr.r.rb;                    // Same position in both views
  assign rf_rd_o = cur_instr.r.rd;

  // Registers actually read by each opcode
  always_comb begin
    use_a = 1'b0;
    use_b = 1'b0;
    use_d = 1'b0;
    case (cur_instr.r.opcode)
      cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::MUL, cpu_pkg::OR, cpu_pkg::XOR,
      cpu_pkg::BEQ, cpu_pkg::BNE, cpu_pkg::BLT, cpu_pkg::BGE: begin
        use_a = 1'b1;
        use_b = 1'b1;
      end
      cpu_pkg::LW:  use_b = 1'b1;
      cpu_pkg::SW: begin
        use_b = 1'b1;
        use_d = 1'b1;
      end
      cpu_pkg::JMP: use_a = 1'b1;
      default: ;
    endcase
  end

  assign hit_a = (ex_we_i && ex_rd_i == rf_ra_o) || (wb_we_i && wb_rd_i == rf_ra_o);
  assign hit_b = (ex_we_i && ex_rd_i == rf_rb_o) || (wb_we_i && wb_rd_i == rf_rb_o);
  assign hit_d = (ex_we_i && ex_rd_i == rf_rd_o) || (wb_we_i && wb_rd_i == rf_rd_o);

  assign stall_o = cur_valid && !redirect_i &&
                   ((use_a && hit_a) || (use_b && hit_b) || (use_d && hit_d));

  always_ff @(posedge clk) begin
    if (!rst) begin
      hold_q   <= 1'b0;
      dx.valid <= 1'b0;
    end else begin
      hold_q   <= stall_o;
      dx.valid <= cur_valid && !stall_o && !redirect_i;  // Bubble on stall or flush
    end
  end

  always_ff @(posedge clk) begin
    if (stall_o) begin
      held_pc_q    <= cur_pc;
      held_instr_q <= cur_instr;
    end
    dx.pc    <= cur_pc;
    dx.instr <= cur_instr;
    dx.op_a  <= rf_a_i;
    dx.op_b  <= rf_b_i;
    dx.op_d  <= rf_d_i;
  end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [cpu_pkg::REG_IDX_WIDTH-1:0] ra_i,
  input  logic [cpu_pkg::REG_IDX_WIDTH-1:0] rb_i,
  input  logic [cpu_pkg::REG_IDX_WIDTH-1:0] rd_i,
  output cpu_pkg::word_t                    a_o,
  output cpu_pkg::word_t                    b_o,
  output cpu_pkg::word_t                    d_o,
  input  logic                              we_i,
  input  logic [cpu_pkg::REG_IDX_WIDTH-1:0] wr_idx_i,
  input  cpu_pkg::word_t                    wr_data_i
);

  cpu_pkg::word_t regs_q [2**cpu_pkg::REG_IDX_WIDTH];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 2**cpu_pkg::REG_IDX_WIDTH; i++) begin
        regs_q[i] <= cpu_pkg::word_t'(i);             // Register i starts at i
      end
    end else if (we_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  assign a_o = regs_q[ra_i];
  assign b_o = regs_q[rb_i];
  assign d_o = regs_q[rd_i];                          // Store data for SW

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  logic                              clk,
  input  logic                              rst,
  dec_ex_if.sink                            dx,
  ex_wb_if.source                           xw,
  output cpu_pkg::addr_t                    mem_addr_o,
  output logic                              mem_we_o,
  output cpu_pkg::word_t                    mem_wdata_o,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] ex_rd_o,
  output logic                              ex_we_o,
  output logic                              redirect_o,
  output cpu_pkg::addr_t                    redirect_pc_o
);

  cpu_pkg::word_t offset_ext;
  cpu_pkg::word_t alu_result;
  cpu_pkg::addr_t branch_target;
  logic           writes_reg;
  logic           taken;
  logic           is_load;

  assign offset_ext = {{(cpu_pkg::DATA_WIDTH-cpu_pkg::OFFSET_WIDTH){
                         dx.instr.m.offset[cpu_pkg::OFFSET_WIDTH-1]}}, dx.instr.m.offset};
  assign mem_addr_o = cpu_pkg::addr_t'(offset_ext + dx.op_b);  // Wraps to 12 bits

  assign branch_target = cpu_pkg::addr_t'(dx.pc + {dx.instr.r.free, dx.instr.r.rd});

  always_comb begin
    alu_result = '0;
    writes_reg = 1'b0;
    taken      = 1'b0;
    case (dx.instr.r.opcode)
      cpu_pkg::ADD: begin
        alu_result = dx.op_a + dx.op_b;
        writes_reg = 1'b1;
      end
      cpu_pkg::LW:  writes_reg = 1'b1;                // Data comes in writeback
      cpu_pkg::SUB: begin
        alu_result = dx.op_a - dx.op_b;
        writes_reg = 1'b1;
      end
      cpu_pkg::AND: begin
        alu_result = dx.op_a & dx.op_b;
        writes_reg = 1'b1;
      end
      cpu_pkg::MUL: begin
        alu_result = dx.op_a * dx.op_b;               // Low 32 bits
        writes_reg = 1'b1;
      end
      cpu_pkg::OR: begin
        alu_result = dx.op_a | dx.op_b;
        writes_reg = 1'b1;
      end
      cpu_pkg::XOR: begin
        alu_result = dx.op_a ^ dx.op_b;
        writes_reg = 1'b1;
      end
      cpu_pkg::BEQ: taken = dx.op_a == dx.op_b;
      cpu_pkg::BNE: taken = dx.op_a != dx.op_b;
      cpu_pkg::BLT: taken = dx.op_a < dx.op_b;        // Unsigned compare
      cpu_pkg::BGE: taken = dx.op_a >= dx.op_b;
      cpu_pkg::JMP: taken = 1'b1;
      default: ;
    endcase
  end

  assign is_load     = dx.valid && dx.instr.m.opcode == cpu_pkg::LW;
  assign mem_we_o    = dx.valid && dx.instr.m.opcode == cpu_pkg::SW;
  assign mem_wdata_o = dx.op_d;

  assign ex_rd_o = dx.instr.r.rd;
  assign ex_we_o = dx.valid && writes_reg;

  assign redirect_o    = dx.valid && taken;
  assign redirect_pc_o = (dx.instr.r.opcode == cpu_pkg::JMP) ? cpu_pkg::addr_t'(dx.op_a)
                                                              : branch_target;

  always_ff @(posedge clk) begin
    if (!rst) begin
      xw.valid    <= 1'b0;
      xw.reg_we   <= 1'b0;
      xw.is_load  <= 1'b0;
      xw.store_en <= 1'b0;
    end else begin
      xw.valid    <= dx.valid;
      xw.reg_we   <= ex_we_o;
      xw.is_load  <= is_load;
      xw.store_en <= mem_we_o;
    end
  end

  always_ff @(posedge clk) begin
    xw.pc         <= dx.pc;
    xw.instr      <= dx.instr;
    xw.result     <= alu_result;
    xw.store_addr <= mem_addr_o;
    xw.store_data <= dx.op_d;
  end

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
  input  logic                              clk,
  input  logic                              rst,
  ex_wb_if.sink                             xw,
  input  cpu_pkg::word_t                    mem_rdata_i,
  output logic                              rf_we_o,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] rf_idx_o,
  output cpu_pkg::word_t                    rf_data_o,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] wb_rd_o,
  output logic                              wb_we_o,
  output logic                              retire_valid_o,
  output cpu_pkg::addr_t                    retire_pc_o,
  output cpu_pkg::instr_u                   retire_instr_o,
  output logic                              retire_reg_we_o,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] retire_rd_o,
  output cpu_pkg::word_t                    retire_value_o,
  output logic                              retire_store_o,
  output cpu_pkg::addr_t                    retire_store_addr_o,
  output cpu_pkg::word_t                    retire_store_data_o
);

  assign rf_we_o   = xw.valid && xw.reg_we;
  assign rf_idx_o  = xw.instr.r.rd;
  assign rf_data_o = xw.is_load ? mem_rdata_i : xw.result;  // Memory read lands now

  assign wb_rd_o = rf_idx_o;                          // Hazard report to decode
  assign wb_we_o = rf_we_o;

  always_ff @(posedge clk) begin
    if (!rst) begin
      retire_valid_o  <= 1'b0;
      retire_reg_we_o <= 1'b0;
      retire_store_o  <= 1'b0;
    end else begin
      retire_valid_o  <= xw.valid;
      retire_reg_we_o <= rf_we_o;
      retire_store_o  <= xw.valid && xw.store_en;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc_o         <= xw.pc;
    retire_instr_o      <= xw.instr;
    retire_rd_o         <= rf_idx_o;
    retire_value_o      <= rf_data_o;
    retire_store_addr_o <= xw.store_addr;
    retire_store_data_o <= xw.store_data;
  end

endmodule

`default_nettype wire

// ==== hdl/unified_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module unified_memory (
  input  logic           clk,
  input  cpu_pkg::addr_t iaddr_i,
  output cpu_pkg::word_t idata_o,
  input  cpu_pkg::addr_t daddr_i,
  input  logic           dwe_i,
  input  cpu_pkg::word_t dwdata_i,
  output cpu_pkg::word_t drdata_o,
  input  logic           load_we_i,
  input  cpu_pkg::addr_t load_addr_i,
  input  cpu_pkg::word_t load_data_i
);

  cpu_pkg::word_t mem_q [cpu_pkg::MEM_WORDS];

  always_ff @(posedge clk) begin
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i;              // Program load first
    end else if (dwe_i) begin
      mem_q[daddr_i] <= dwdata_i;
    end
    idata_o  <= mem_q[iaddr_i];                       // One cycle read latency
    drdata_o <= mem_q[daddr_i];
  end

endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              run_i,
  input  logic                              load_we_i,
  input  cpu_pkg::addr_t                    load_addr_i,
  input  cpu_pkg::word_t                    load_data_i,
  output logic                              retire_valid_o,
  output cpu_pkg::addr_t                    retire_pc_o,
  output cpu_pkg::instr_u                   retire_instr_o,
  output logic                              retire_reg_we_o,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] retire_rd_o,
  output cpu_pkg::word_t                    retire_value_o,
  output logic                              retire_store_o,
  output cpu_pkg::addr_t                    retire_store_addr_o,
  output cpu_pkg::word_t                    retire_store_data_o
);

  cpu_pkg::addr_t                    fetch_addr;
  logic                              fetch_valid;
  cpu_pkg::addr_t                    fetch_pc;
  cpu_pkg::instr_u                   fetch_instr;
  logic                              stall;
  logic                              redirect;
  cpu_pkg::addr_t                    redirect_pc;
  logic [cpu_pkg::REG_IDX_WIDTH-1:0] rf_ra;
  logic [cpu_pkg::REG_IDX_WIDTH-1:0] rf_rb;
  logic [cpu_pkg::REG_IDX_WIDTH-1:0] rf_rd;
  cpu_pkg::word_t                    rf_a;
  cpu_pkg::word_t                    rf_b;
  cpu_pkg::word_t                    rf_d;
  logic                              rf_we;
  logic [cpu_pkg::REG_IDX_WIDTH-1:0] rf_idx;
  cpu_pkg::word_t                    rf_data;
  logic [cpu_pkg::REG_IDX_WIDTH-1:0] ex_rd;
  logic                              ex_we;
  logic [cpu_pkg::REG_IDX_WIDTH-1:0] wb_rd;
  logic                              wb_we;
  cpu_pkg::addr_t                    mem_addr;
  logic                              mem_we;
  cpu_pkg::word_t                    mem_wdata;
  cpu_pkg::word_t                    mem_rdata;

  dec_ex_if dx ();
  ex_wb_if  xw ();

  fetch_stage u_fetch (
    .clk           (clk),
    .rst           (rst),
    .run_i         (run_i),
    .stall_i       (stall),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .fetch_addr_o  (fetch_addr),
    .fetch_valid_o (fetch_valid),
    .fetch_pc_o    (fetch_pc)
  );

  decode_stage u_decode (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid),
    .fetch_pc_i    (fetch_pc),
    .fetch_instr_i (fetch_instr),
    .redirect_i    (redirect),
    .ex_rd_i       (ex_rd),
    .ex_we_i       (ex_we),
    .wb_rd_i       (wb_rd),
    .wb_we_i       (wb_we),
    .rf_ra_o       (rf_ra),
    .rf_rb_o       (rf_rb),
    .rf_rd_o       (rf_rd),
    .rf_a_i        (rf_a),
    .rf_b_i        (rf_b),
    .rf_d_i        (rf_d),
    .stall_o       (stall),
    .dx            (dx.source)
  );

  register_file u_regs (
    .clk       (clk),
    .rst       (rst),
    .ra_i      (rf_ra),
    .rb_i      (rf_rb),
    .rd_i      (rf_rd),
    .a_o       (rf_a),
    .b_o       (rf_b),
    .d_o       (rf_d),
    .we_i      (rf_we),
    .wr_idx_i  (rf_idx),
    .wr_data_i (rf_data)
  );

  execute_stage u_execute (
    .clk           (clk),
    .rst           (rst),
    .dx            (dx.sink),
    .xw            (xw.source),
    .mem_addr_o    (mem_addr),
    .mem_we_o      (mem_we),
    .mem_wdata_o   (mem_wdata),
    .ex_rd_o       (ex_rd),
    .ex_we_o       (ex_we),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  writeback_stage u_writeback (
    .clk                 (clk),
    .rst                 (rst),
    .xw                  (xw.sink),
    .mem_rdata_i         (mem_rdata),
    .rf_we_o             (rf_we),
    .rf_idx_o            (rf_idx),
    .rf_data_o           (rf_data),
    .wb_rd_o             (wb_rd),
    .wb_we_o             (wb_we),
    .retire_valid_o      (retire_valid_o),
    .retire_pc_o         (retire_pc_o),
    .retire_instr_o      (retire_instr_o),
    .retire_reg_we_o     (retire_reg_we_o),
    .retire_rd_o         (retire_rd_o),
    .retire_value_o      (retire_value_o),
    .retire_store_o      (retire_store_o),
    .retire_store_addr_o (retire_store_addr_o),
    .retire_store_data_o (retire_store_data_o)
  );

  unified_memory u_mem (
    .clk         (clk),
    .iaddr_i     (fetch_addr),
    .idata_o     (fetch_instr),                       // Same 32 bits, decoded as a union
    .daddr_i     (mem_addr),
    .dwe_i       (mem_we),
    .dwdata_i    (mem_wdata),
    .drdata_o    (mem_rdata),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

endmodule

`default_nettype wire

// ==== verification/cpu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_checker (
  input  logic clk,
  input  logic rst,
  input  logic run_i,
  input  logic retire_valid_i,
  input  logic retire_reg_we_i,
  input  logic retire_store_i
);

  // Nothing can retire before the program runs
  no_retire_idle: assert property (@(posedge clk) disable iff (!rst)
    !run_i |-> !retire_valid_i)
    else $error("retire while run_i is low");

  strobes_after_reset: assert property (@(posedge clk)
    !rst |=> !retire_valid_i && !retire_store_i)
    else $error("retire or store strobe high after reset");

  store_no_reg_write: assert property (@(posedge clk) disable iff (!rst)
    retire_store_i |-> !retire_reg_we_i)
    else $error("store retired with register write");

endmodule

bind cpu_top cpu_checker u_checker (
  .clk             (clk),
  .rst             (rst),
  .run_i           (run_i),
  .retire_valid_i  (retire_valid_o),
  .retire_reg_we_i (retire_reg_we_o),
  .retire_store_i  (retire_store_o)
);

`default_nettype wire

// ==== verification/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

  localparam int PROG_WORDS      = 64;                // Program at 0..63, data at 2048 up
  localparam int NUM_RETIRES     = 300;
  localparam int WATCHDOG_CYCLES = 4096 + 16 + 10 * NUM_RETIRES;

  logic                              clk;
  logic                              rst;
  logic                              run_i;
  logic                              load_we_i;
  cpu_pkg::addr_t                    load_addr_i;
  cpu_pkg::word_t                    load_data_i;
  logic                              retire_valid_o;
  cpu_pkg::addr_t                    retire_pc_o;
  cpu_pkg::instr_u                   retire_instr_o;
  logic                              retire_reg_we_o;
  logic [cpu_pkg::REG_IDX_WIDTH-1:0] retire_rd_o;
  cpu_pkg::word_t                    retire_value_o;
  logic                              retire_store_o;
  cpu_pkg::addr_t                    retire_store_addr_o;
  cpu_pkg::word_t                    retire_store_data_o;

  logic [31:0]                       lfsr_state;
  cpu_pkg::word_t                    model_mem [cpu_pkg::MEM_WORDS];
  cpu_pkg::word_t                    model_regs [32];
  cpu_pkg::addr_t                    model_pc;
  cpu_pkg::addr_t                    exp_pc;
  cpu_pkg::instr_u                   exp_instr;
  logic                              exp_we;
  logic [cpu_pkg::REG_IDX_WIDTH-1:0] exp_rd;
  cpu_pkg::word_t                    exp_value;
  logic                              exp_store;
  cpu_pkg::addr_t                    exp_saddr;
  cpu_pkg::word_t                    exp_sdata;
  int                                error_count;
  int                                check_count;
  int                                retire_count;

  cpu_top UUT (
    .clk                 (clk),
    .rst                 (rst),
    .run_i               (run_i),
    .load_we_i           (load_we_i),
    .load_addr_i         (load_addr_i),
    .load_data_i         (load_data_i),
    .retire_valid_o      (retire_valid_o),
    .retire_pc_o         (retire_pc_o),
    .retire_instr_o      (retire_instr_o),
    .retire_reg_we_o     (retire_reg_we_o),
    .retire_rd_o         (retire_rd_o),
    .retire_value_o      (retire_value_o),
    .retire_store_o      (retire_store_o),
    .retire_store_addr_o (retire_store_addr_o),
    .retire_store_data_o (retire_store_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic cpu_pkg::word_t rand_bits(input int n);
    cpu_pkg::word_t val;
    logic           fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  // Stores and loads use r0..r15 as base, which are never written
  function automatic cpu_pkg::word_t make_instr(input cpu_pkg::addr_t at);
    logic [3:0]     op;
    logic [4:0]     ra;
    logic [4:0]     rb;
    logic [4:0]     rd;
    logic [12:0]    free;
    logic [17:0]    off;
    cpu_pkg::addr_t tgt;
    cpu_pkg::addr_t imm;
    op   = 4'(rand_bits(4));
    ra   = 5'(rand_bits(5));
    rb   = 5'(rand_bits(5));
    rd   = {1'b1, 4'(rand_bits(4))};                  // ALU and LW write r16..r31
    free = 13'(rand_bits(13));
    case (op)
      4'd1, 4'd2: begin
        rb  = {1'b0, 4'(rand_bits(4))};
        tgt = 12'd2048 + cpu_pkg::addr_t'(rand_bits(4));
        off = 18'(tgt) - 18'(rb);
        if (rand_bits(1) != 0) begin
          off = off - 18'd4096;                       // Negative offset, same address
        end
        if (op == 4'd2) begin
          rd = 5'(rand_bits(5));
        end
        return {off, rb, rd, op};
      end
      4'd9, 4'd10, 4'd11, 4'd12: begin
        tgt = cpu_pkg::addr_t'(rand_bits(6));          // Stay inside the program
        imm = tgt - at;
        if (op == 4'd9 && rand_bits(1) != 0) begin
          rb = ra;
        end
        return {free[12:7], imm[11:5], ra, rb, imm[4:0], op};
      end
      4'd13: return {free, 1'b0, ra[3:0], rb, rd, op};
      default: return {free, ra, rb, rd, op};
    endcase
  endfunction

  // Executes the instruction at the model PC
  function automatic void reference_step();
    cpu_pkg::instr_u ins;
    cpu_pkg::word_t  a;
    cpu_pkg::word_t  b;
    cpu_pkg::word_t  d;
    cpu_pkg::word_t  ext;
    cpu_pkg::addr_t  ea;
    cpu_pkg::addr_t  imm;
    cpu_pkg::addr_t  next_pc;
    ins       = model_mem[model_pc];
    a         = model_regs[ins.r.ra];
    b         = model_regs[ins.r.rb];
    d         = model_regs[ins.r.rd];
    ext       = {{14{ins.m.offset[17]}}, ins.m.offset};
    ea        = cpu_pkg::addr_t'(ext + b);
    imm       = {ins.r.free[6:0], ins.r.rd};
    next_pc   = model_pc + 12'd1;
    exp_pc    = model_pc;
    exp_instr = ins;
    exp_rd    = ins.r.rd;
    exp_we    = 1'b0;
    exp_value = '0;
    exp_store = 1'b0;
    exp_saddr = '0;
    exp_sdata = '0;
    case (ins.r.opcode)
      cpu_pkg::ADD: {exp_we, exp_value} = {1'b1, a + b};
      cpu_pkg::SUB: {exp_we, exp_value} = {1'b1, a - b};
      cpu_pkg::AND: {exp_we, exp_value} = {1'b1, a & b};
      cpu_pkg::MUL: {exp_we, exp_value} = {1'b1, cpu_pkg::word_t'(a * b)};
      cpu_pkg::OR:  {exp_we, exp_value} = {1'b1, a | b};
      cpu_pkg::XOR: {exp_we, exp_value} = {1'b1, a ^ b};
      cpu_pkg::LW:  {exp_we, exp_value} = {1'b1, model_mem[ea]};
      cpu_pkg::SW: begin
        exp_store     = 1'b1;
        exp_saddr     = ea;
        exp_sdata     = d;
        model_mem[ea] = d;
      end
      cpu_pkg::BEQ: if (a == b) next_pc = model_pc + imm;
      cpu_pkg::BNE: if (a != b) next_pc = model_pc + imm;
      cpu_pkg::BLT: if (a < b) next_pc = model_pc + imm;
      cpu_pkg::BGE: if (a >= b) next_pc = model_pc + imm;
      cpu_pkg::JMP: next_pc = a[11:0];
      default: ;                                      // Unused opcodes do nothing
    endcase
    if (exp_we) begin
      model_regs[ins.r.rd] = exp_value;
    end
    model_pc = next_pc;
  endfunction

  task automatic check_instr(input string name, input cpu_pkg::instr_u got,
                             input cpu_pkg::instr_u exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name,
               cpu_pkg::word_t'(got), cpu_pkg::word_t'(exp));
    end
  endtask

  task automatic check_word(input string name, input cpu_pkg::word_t got,
                            input cpu_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input cpu_pkg::addr_t got,
                            input cpu_pkg::addr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_idx(input string name, input logic [4:0] got, input logic [4:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic load_word(input cpu_pkg::addr_t addr, input cpu_pkg::word_t data);
    @(posedge clk);
    load_we_i      <= 1'b1;
    load_addr_i    <= addr;
    load_data_i    <= data;
    model_mem[addr] = data;
  endtask

  // Outputs change on the rising edge, so sample on the falling one
  always @(negedge clk) begin
    if (rst && retire_valid_o && retire_count < NUM_RETIRES) begin
      reference_step();
      check_addr("retire_pc_o", retire_pc_o, exp_pc);
      check_instr("retire_instr_o", retire_instr_o, exp_instr);
      check_flag("retire_reg_we_o", retire_reg_we_o, exp_we);
      check_idx("retire_rd_o", retire_rd_o, exp_rd);
      if (exp_we) begin
        check_word("retire_value_o", retire_value_o, exp_value);
      end
      check_flag("retire_store_o", retire_store_o, exp_store);
      if (exp_store) begin
        check_addr("retire_store_addr_o", retire_store_addr_o, exp_saddr);
        check_word("retire_store_data_o", retire_store_data_o, exp_sdata);
      end
      retire_count++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d instructions retired",
             WATCHDOG_CYCLES, retire_count, NUM_RETIRES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst          = 1'b0;
    run_i        = 1'b0;
    load_we_i    = 1'b0;
    load_addr_i  = '0;
    load_data_i  = '0;
    lfsr_state   = 32'h96f6;
    error_count  = 0;
    check_count  = 0;
    retire_count = 0;
    model_pc     = cpu_pkg::RESET_PC;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = cpu_pkg::word_t'(i);
    end
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
      load_word(cpu_pkg::addr_t'(i), cpu_pkg::word_t'(i * 100));
    end
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      load_word(cpu_pkg::addr_t'(i), make_instr(cpu_pkg::addr_t'(i)));
    end
    // Last word jumps back to r1, which holds 1
    load_word(cpu_pkg::addr_t'(PROG_WORDS - 1), {13'd0, 5'd1, 5'd0, 5'd0, 4'd13});
    @(posedge clk);
    load_we_i <= 1'b0;
    run_i     <= 1'b1;
    wait (retire_count == NUM_RETIRES);
    @(posedge clk);
    $display("Retired %0d instructions, %0d checks, %0d errors",
             retire_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== toy_cpu.f ====
hdl/cpu_pkg.sv
hdl/pipe_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/unified_memory.sv
hdl/cpu_top.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f toy_cpu.f --top-module cpu_tb -o Vcpu_tb

run: compile
	./obj_dir/Vcpu_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
